// File: Bender.yml
package:
  name: hal

sources:
  - design/hal_pkg.sv
  - design/hps_cfg_regs.sv
  - design/video_window_calc.sv
  - design/sync_polarity_fix.sv
  - design/csync_gen.sv
  - design/hal_top.sv
  - target: simulation
    files:
      - verif/hal_tb.sv

// File: design/csync_gen.sv
/*
 * Composite sync from active-high hsync and vsync,
 * serrated hsync pulses during vsync
 */

`timescale 1ns/1ps

module csync_gen import hal_pkg::*; (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hsync,
	input  logic i_vsync,
	output logic o_csync
);

	logic     hs_prev_q;
	logic     cs_hs_q;
	logic     cs_vs_q;
	logic     hs_edge;
	run_len_t h_cnt_q;
	run_len_t line_len_q;
	run_len_t hs_len_q;

	assign hs_edge = hs_prev_q ^ i_hsync;

	assign o_csync = cs_hs_q ^ cs_vs_q;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_prev_q  <= 1'b0;
			cs_hs_q    <= 1'b0;
			cs_vs_q    <= 1'b0;
			h_cnt_q    <= '0;
			line_len_q <= '0;
			hs_len_q   <= '0;
		end else begin
			hs_prev_q <= i_hsync;

			// Line and hsync width measurement
			if (hs_edge) begin
				h_cnt_q <= '0;
				if (i_hsync)
					line_len_q <= h_cnt_q - hs_len_q;
				else
					hs_len_q <= h_cnt_q;
			end else begin
				h_cnt_q <= h_cnt_q + 1'b1;
			end

			// Inside vsync the pulse moves one hsync width early
			if (!i_vsync)
				cs_hs_q <= i_hsync;
			else if (h_cnt_q == line_len_q)
				cs_hs_q <= 1'b1;
			else if (hs_edge && i_hsync)
				cs_hs_q <= 1'b0;

			cs_vs_q <= i_vsync;
		end
	end

endmodule

// File: design/hal_pkg.sv
/*
 * Shared widths, vector types, host command codes, reset defaults
 * and state encodings for the hardware abstraction blocks
 */

package hal_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	localparam int IO_W       = 16;
	localparam int CMD_W      = 8;
	localparam int DIM_W      = 12;
	localparam int LED_W      = 8;
	localparam int VOL_W      = 5;
	localparam int CFG_W      = 16;
	// Sync run length and line length counters
	localparam int RUN_LEN_W  = 16;
	// Data word index inside one host frame, saturating
	localparam int WORD_CNT_W = 4;

	typedef logic [IO_W-1:0]      io_word_t;
	typedef logic [CMD_W-1:0]     cmd_code_t;
	typedef logic [DIM_W-1:0]     dim_t;
	typedef logic [LED_W-1:0]     led_vec_t;
	typedef logic [VOL_W-1:0]     vol_att_t;
	typedef logic [CFG_W-1:0]     cfg_word_t;
	typedef logic [RUN_LEN_W-1:0] run_len_t;

	//////////////////////////////////////////////////////////////////////
	// Host commands
	//////////////////////////////////////////////////////////////////////

	localparam cmd_code_t CMD_CFG    = 8'h01;
	localparam cmd_code_t CMD_TIMING = 8'h20;
	localparam cmd_code_t CMD_LED    = 8'h25;
	localparam cmd_code_t CMD_VOL    = 8'h26;
	localparam cmd_code_t CMD_VSET   = 8'h27;
	localparam cmd_code_t CMD_HSET   = 8'h37;
	localparam cmd_code_t CMD_ARC    = 8'h3A;

	// Timing frame layout, only active size is kept
	localparam int TIMING_WORDS      = 8;
	localparam int TIMING_WIDTH_IDX  = 0;
	localparam int TIMING_HEIGHT_IDX = 4;

	// 1920x1080 output until the host says otherwise
	localparam dim_t DEFAULT_WIDTH  = 12'd1920;
	localparam dim_t DEFAULT_HEIGHT = 12'd1080;

	//////////////////////////////////////////////////////////////////////
	// Window calculator
	//////////////////////////////////////////////////////////////////////

	localparam int WIN_CYCLE   = 8;
	localparam int WIN_PHASE_W = $clog2(WIN_CYCLE);

	typedef enum logic {
		PARSE_IDLE,
		PARSE_DATA
	} parse_state_t;

	typedef enum logic [1:0] {
		WIN_LOAD,
		WIN_WAIT,
		WIN_CLAMP,
		WIN_PLACE
	} win_state_t;

endpackage

// File: design/hal_top.sv
/*
 * Top level: host config registers, window calculator, sync conditioning
 */

`timescale 1ns/1ps

module hal_top import hal_pkg::*; (
	input  logic       clk_sys,
	input  logic       resetd,
	input  logic       i_io_uio,
	input  logic       i_io_strobe,
	input  io_word_t   i_io_din,
	input  dim_t       i_video_arx,
	input  dim_t       i_video_ary,
	input  logic       i_led_user,
	input  logic [1:0] i_led_power,
	input  logic [1:0] i_led_disk,
	input  logic       i_hs_raw,
	input  logic       i_vs_raw,
	output led_vec_t   o_led,
	output cfg_word_t  o_cfg,
	output vol_att_t   o_vol_att,
	output dim_t       o_hmin,
	output dim_t       o_hmax,
	output dim_t       o_vmin,
	output dim_t       o_vmax,
	output logic       o_hs,
	output logic       o_vs,
	output logic       o_csync
);

	// Host settings toward the window calculator
	dim_t width, height, vset, hset;
	dim_t arc1x, arc1y, arc2x, arc2y;
	logic freescale;

	hps_cfg_regs i_hps_cfg_regs (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.i_led_user  (i_led_user),
		.i_led_power (i_led_power),
		.i_led_disk  (i_led_disk),
		.o_led       (o_led),
		.o_cfg       (o_cfg),
		.o_vol_att   (o_vol_att),
		.o_width     (width),
		.o_height    (height),
		.o_vset      (vset),
		.o_hset      (hset),
		.o_freescale (freescale),
		.o_arc1x     (arc1x),
		.o_arc1y     (arc1y),
		.o_arc2x     (arc2x),
		.o_arc2y     (arc2y)
	);

	video_window_calc i_video_window_calc (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_width     (width),
		.i_height    (height),
		.i_vset      (vset),
		.i_hset      (hset),
		.i_freescale (freescale),
		.i_arc1x     (arc1x),
		.i_arc1y     (arc1y),
		.i_arc2x     (arc2x),
		.i_arc2y     (arc2y),
		.i_video_arx (i_video_arx),
		.i_video_ary (i_video_ary),
		.o_hmin      (o_hmin),
		.o_hmax      (o_hmax),
		.o_vmin      (o_vmin),
		.o_vmax      (o_vmax)
	);

	//////////////////////////////////////////////////////////////////////
	// Sync path
	//////////////////////////////////////////////////////////////////////

	sync_polarity_fix i_sync_fix_h (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs_raw),
		.o_sync  (o_hs)
	);

	sync_polarity_fix i_sync_fix_v (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs_raw),
		.o_sync  (o_vs)
	);

	csync_gen i_csync_gen (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_hsync (o_hs),
		.i_vsync (o_vs),
		.o_csync (o_csync)
	);

endmodule

// File: design/hps_cfg_regs.sv
/*
 * Host command parser, configuration registers and board LED merger
 */

`timescale 1ns/1ps

module hps_cfg_regs import hal_pkg::*; (
	input  logic      clk_sys,
	input  logic      resetd,
	input  logic      i_io_uio,
	input  logic      i_io_strobe,
	input  io_word_t  i_io_din,
	input  logic      i_led_user,
	input  logic [1:0] i_led_power,
	input  logic [1:0] i_led_disk,
	output led_vec_t  o_led,
	output cfg_word_t o_cfg,
	output vol_att_t  o_vol_att,
	output dim_t      o_width,
	output dim_t      o_height,
	output dim_t      o_vset,
	output dim_t      o_hset,
	output logic      o_freescale,
	output dim_t      o_arc1x,
	output dim_t      o_arc1y,
	output dim_t      o_arc2x,
	output dim_t      o_arc2y
);

	parse_state_t            state_q;
	cmd_code_t               cmd_q;
	logic [WORD_CNT_W-1:0]   word_cnt_q;
	logic                    word_take;
	logic                    data_take;

	led_vec_t led_ovt_q;
	led_vec_t led_st_q;
	led_vec_t led_ovt_next;
	led_vec_t led_st_next;
	led_vec_t led_dflt;
	logic     led_wr;

	// A word counts only inside a frame
	assign word_take = i_io_uio & i_io_strobe;
	assign data_take = word_take && (state_q == PARSE_DATA);

	//////////////////////////////////////////////////////////////////////
	// Frame parser
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state_q    <= PARSE_IDLE;
			cmd_q      <= '0;
			word_cnt_q <= '0;
		end else if (!i_io_uio) begin
			state_q <= PARSE_IDLE;
		end else if (word_take) begin
			if (state_q == PARSE_IDLE) begin
				// First word of the frame is the command
				state_q    <= PARSE_DATA;
				cmd_q      <= i_io_din[CMD_W-1:0];
				word_cnt_q <= '0;
			end else if (word_cnt_q != '1) begin
				word_cnt_q <= word_cnt_q + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Configuration registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_cfg       <= '0;
			o_vol_att   <= '0;
			o_width     <= DEFAULT_WIDTH;
			o_height    <= DEFAULT_HEIGHT;
			o_vset      <= '0;
			o_hset      <= '0;
			o_freescale <= 1'b0;
			o_arc1x     <= '0;
			o_arc1y     <= '0;
			o_arc2x     <= '0;
			o_arc2y     <= '0;
		end else if (data_take) begin
			case (cmd_q)
				CMD_CFG:  o_cfg     <= i_io_din;
				CMD_VOL:  o_vol_att <= i_io_din[VOL_W-1:0];
				CMD_VSET: o_vset    <= i_io_din[DIM_W-1:0];
				CMD_HSET: begin
					o_freescale <= i_io_din[15];
					o_hset      <= i_io_din[DIM_W-1:0];
				end
				CMD_TIMING: begin
					// Porch and sync words are only counted
					if (word_cnt_q < WORD_CNT_W'(TIMING_WORDS)) begin
						if (word_cnt_q == WORD_CNT_W'(TIMING_WIDTH_IDX))
							o_width <= i_io_din[DIM_W-1:0];
						if (word_cnt_q == WORD_CNT_W'(TIMING_HEIGHT_IDX))
							o_height <= i_io_din[DIM_W-1:0];
					end
				end
				CMD_ARC: begin
					case (word_cnt_q)
						WORD_CNT_W'(0): o_arc1x <= i_io_din[DIM_W-1:0];
						WORD_CNT_W'(1): o_arc1y <= i_io_din[DIM_W-1:0];
						WORD_CNT_W'(2): o_arc2x <= i_io_din[DIM_W-1:0];
						WORD_CNT_W'(3): o_arc2y <= i_io_din[DIM_W-1:0];
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// LED merge
	//////////////////////////////////////////////////////////////////////

	assign led_wr       = data_take && (cmd_q == CMD_LED);
	assign led_ovt_next = led_wr ? i_io_din[15:8] : led_ovt_q;
	assign led_st_next  = led_wr ? i_io_din[7:0] : led_st_q;

	// Core pattern: user on bit 0, disk on bit 2, power on bit 4
	assign led_dflt = {3'b000, &i_led_power, 1'b0, i_led_disk[0], 1'b0, i_led_user};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			led_ovt_q <= '0;
			led_st_q  <= '0;
			o_led     <= '0;
		end else begin
			led_ovt_q <= led_ovt_next;
			led_st_q  <= led_st_next;
			o_led     <= (led_ovt_next & led_st_next) | (~led_ovt_next & led_dflt);
		end
	end

	// Data words within a frame never bring the index back to zero
	a_word_cnt_no_wrap: assert property (@(posedge clk_sys) disable iff (resetd)
		data_take |=> (word_cnt_q != '0));

endmodule

// File: design/sync_polarity_fix.sv
/*
 * Sync polarity fixer, pulse driven out active high
 */

`timescale 1ns/1ps

module sync_polarity_fix import hal_pkg::*; (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic     sync_m, sync_s;
	logic     pol_q;
	run_len_t run_cnt_q;
	run_len_t high_len_q;
	run_len_t low_len_q;

	// Pulse is whichever level is shorter
	assign o_sync = i_sync ^ pol_q;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_m     <= 1'b0;
			sync_s     <= 1'b0;
			run_cnt_q  <= '0;
			high_len_q <= '0;
			low_len_q  <= '0;
			pol_q      <= 1'b0;
		end else begin
			sync_m <= i_sync;
			sync_s <= sync_m;
			if (sync_m != sync_s) begin
				// Level just ended, keep its length
				run_cnt_q <= '0;
				if (sync_s)
					high_len_q <= run_cnt_q;
				else
					low_len_q <= run_cnt_q;
			end else if (run_cnt_q != '1) begin
				run_cnt_q <= run_cnt_q + 1'b1;
			end
			pol_q <= high_len_q > low_len_q;
		end
	end

endmodule

// File: design/video_window_calc.sv
/*
 * Display window bounds with the picture centred from the aspect ratio
 */

`timescale 1ns/1ps

module video_window_calc import hal_pkg::*; (
	input  logic clk_sys,
	input  logic resetd,
	input  dim_t i_width,
	input  dim_t i_height,
	input  dim_t i_vset,
	input  dim_t i_hset,
	input  logic i_freescale,
	input  dim_t i_arc1x,
	input  dim_t i_arc1y,
	input  dim_t i_arc2x,
	input  dim_t i_arc2y,
	input  dim_t i_video_arx,
	input  dim_t i_video_ary,
	output dim_t o_hmin,
	output dim_t o_hmax,
	output dim_t o_vmin,
	output dim_t o_vmax
);

	win_state_t             state_q;
	logic [WIN_PHASE_W-1:0] phase_q;

	dim_t width_q, height_q;
	dim_t eff_w_q, eff_h_q, arx_q, ary_q;
	dim_t full_w_q, full_h_q, snap_w_q, snap_h_q, snap_arx_q, snap_ary_q;
	logic use_ratio_q;
	dim_t video_w_q, video_h_q;
	dim_t hmin_calc, vmin_calc;

	logic [2*DIM_W-1:0] w_prod, h_prod, w_cand, h_cand;

	// Full size, effective size and aspect terms in one register stage
	always_ff @(posedge clk_sys) begin
		width_q  <= i_width;
		height_q <= i_height;
		eff_h_q <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;
		eff_w_q <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
		if (i_video_ary == '0) begin
			case (i_video_arx)
				DIM_W'(1): begin
					arx_q <= i_arc1x;
					ary_q <= i_arc1y;
				end
				DIM_W'(2): begin
					arx_q <= i_arc2x;
					ary_q <= i_arc2y;
				end
				default: begin
					arx_q <= '0;
					ary_q <= '0;
				end
			endcase
		end else begin
			arx_q <= i_video_arx;
			ary_q <= i_video_ary;
		end
	end

	// Divider operands held from WIN_LOAD through WIN_WAIT
	assign w_prod = (2*DIM_W)'(snap_h_q) * (2*DIM_W)'(snap_arx_q);
	assign h_prod = (2*DIM_W)'(snap_w_q) * (2*DIM_W)'(snap_ary_q);
	assign w_cand = use_ratio_q ? w_prod / (2*DIM_W)'(snap_ary_q) : (2*DIM_W)'(snap_w_q);
	assign h_cand = use_ratio_q ? h_prod / (2*DIM_W)'(snap_arx_q) : (2*DIM_W)'(snap_h_q);

	assign hmin_calc = (full_w_q - video_w_q) >> 1;
	assign vmin_calc = (full_h_q - video_h_q) >> 1;

	always_ff @(posedge clk_sys) begin
		if (state_q == WIN_LOAD) begin
			full_w_q    <= width_q;
			full_h_q    <= height_q;
			snap_w_q    <= eff_w_q;
			snap_h_q    <= eff_h_q;
			snap_arx_q  <= arx_q;
			snap_ary_q  <= ary_q;
			use_ratio_q <= !(i_freescale || arx_q == '0 || ary_q == '0);
		end
		if (state_q == WIN_CLAMP) begin
			video_w_q <= (w_cand > (2*DIM_W)'(snap_w_q)) ? snap_w_q : w_cand[DIM_W-1:0];
			video_h_q <= (h_cand > (2*DIM_W)'(snap_h_q)) ? snap_h_q : h_cand[DIM_W-1:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Free running calculation cycle
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state_q <= WIN_LOAD;
			phase_q <= '0;
			o_hmin  <= '0;
			o_hmax  <= '0;
			o_vmin  <= '0;
			o_vmax  <= '0;
		end else begin
			phase_q <= (state_q == WIN_PLACE) ? '0 : phase_q + 1'b1;
			case (state_q)
				WIN_LOAD: state_q <= WIN_WAIT;
				WIN_WAIT: begin
					if (phase_q == WIN_PHASE_W'(WIN_CYCLE - 3))
						state_q <= WIN_CLAMP;
				end
				WIN_CLAMP: state_q <= WIN_PLACE;
				WIN_PLACE: begin
					o_hmin  <= hmin_calc;
					o_hmax  <= hmin_calc + video_w_q - 1'b1;
					o_vmin  <= vmin_calc;
					o_vmax  <= vmin_calc + video_h_q - 1'b1;
					state_q <= WIN_LOAD;
				end
				default: state_q <= WIN_LOAD;
			endcase
		end
	end

	a_hbounds_order: assert property (@(posedge clk_sys) disable iff (resetd)
		(state_q == WIN_PLACE && video_w_q != '0) |=> (o_hmax >= o_hmin));

endmodule

// File: sim.f
design/hal_pkg.sv
design/hps_cfg_regs.sv
design/video_window_calc.sv
design/sync_polarity_fix.sv
design/csync_gen.sv
design/hal_top.sv
verif/hal_tb.sv

// File: verif/hal_tb.sv
/*
 * Testbench for hal_top with host frames, LED merge, window bounds
 * and sync conditioning
 */

`timescale 1ns/1ps

module hal_tb import hal_pkg::*; ();

	localparam int WIN_SETTLE = 24;
	localparam int ITERS      = 4;
	localparam int HS_PERIOD  = 40;
	localparam int HS_LOW     = 6;
	localparam int VS_PERIOD  = 8 * HS_PERIOD;
	localparam int VS_LOW     = 2 * HS_PERIOD;

	// Cycle budget of each test
	localparam int LEN_RESET   = 4;
	localparam int LEN_T1      = WIN_SETTLE;
	localparam int LEN_T2      = 6 * 3 + 2 * ITERS;
	localparam int LEN_T3      = 2 * ITERS * (TIMING_WORDS + 5 + WIN_SETTLE);
	localparam int LEN_T4      = 12 + 2 * WIN_SETTLE;
	localparam int LEN_T5      = 4 * VS_PERIOD;
	localparam int CYCLE_LIMIT = (LEN_RESET + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5) * 3 / 2;

	logic       clk_sys, resetd, io_uio, io_strobe;
	io_word_t   io_din;
	dim_t       video_arx, video_ary;
	logic       led_user, hs_raw, vs_raw;
	logic [1:0] led_power, led_disk;
	led_vec_t   led;
	cfg_word_t  cfg;
	vol_att_t   vol_att;
	dim_t       hmin, hmax, vmin, vmax;
	logic       hs, vs, csync;

	// Model of the host settings
	dim_t      m_width, m_height, m_vset, m_hset;
	dim_t      m_arc1x, m_arc1y, m_arc2x, m_arc2y;
	logic      m_fs;
	led_vec_t  m_ovt, m_st;
	cfg_word_t m_cfg;
	vol_att_t  m_vol;

	io_word_t    frame_data [TIMING_WORDS];
	logic [31:0] rng;
	int          cycle_cnt = 0;
	int          check_cnt, err_cnt, test_cnt, test_err0;
	int          h_pos, v_pos;
	logic        sync_run, sync_check, prev_hs, prev_vs;

	hal_top i_hal_top (
		.clk_sys (clk_sys), .resetd (resetd),
		.i_io_uio (io_uio), .i_io_strobe (io_strobe), .i_io_din (io_din),
		.i_video_arx (video_arx), .i_video_ary (video_ary),
		.i_led_user (led_user), .i_led_power (led_power), .i_led_disk (led_disk),
		.i_hs_raw (hs_raw), .i_vs_raw (vs_raw),
		.o_led (led), .o_cfg (cfg), .o_vol_att (vol_att),
		.o_hmin (hmin), .o_hmax (hmax), .o_vmin (vmin), .o_vmax (vmax),
		.o_hs (hs), .o_vs (vs), .o_csync (csync)
	);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////////////////////////
	// Reference models
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic led_vec_t ref_led(input led_vec_t ovt, input led_vec_t st,
			input logic user, input logic [1:0] power, input logic [1:0] disk);
		led_vec_t dflt;
		dflt    = '0;
		dflt[0] = user;
		dflt[2] = disk[0];
		dflt[4] = (power == 2'b11);
		return (ovt & st) | (~ovt & dflt);
	endfunction

	// Packed as hmin, hmax, vmin, vmax
	function automatic logic [4*DIM_W-1:0] ref_window(input dim_t w, input dim_t h,
			input dim_t vset, input dim_t hset, input logic fs, input dim_t a1x,
			input dim_t a1y, input dim_t a2x, input dim_t a2y, input dim_t ax, input dim_t ay);
		dim_t ew, eh, rx, ry, vw, vh, h0, h1, v0, v1;
		logic [2*DIM_W-1:0] cw, ch;
		eh = (vset != '0 && vset < h) ? vset : h;
		ew = (hset != '0 && hset < w) ? hset : w;
		rx = ax;
		ry = ay;
		if (ay == '0) begin
			rx = (ax == 12'd1) ? a1x : (ax == 12'd2) ? a2x : '0;
			ry = (ax == 12'd1) ? a1y : (ax == 12'd2) ? a2y : '0;
		end
		if (fs || rx == '0 || ry == '0) begin
			cw = {12'd0, ew};
			ch = {12'd0, eh};
		end else begin
			cw = {12'd0, eh} * {12'd0, rx} / {12'd0, ry};
			ch = {12'd0, ew} * {12'd0, ry} / {12'd0, rx};
		end
		vw = (cw > {12'd0, ew}) ? ew : cw[DIM_W-1:0];
		vh = (ch > {12'd0, eh}) ? eh : ch[DIM_W-1:0];
		h0 = (w - vw) >> 1;
		v0 = (h - vh) >> 1;
		h1 = h0 + vw - 12'd1;
		v1 = v0 + vh - 12'd1;
		return {h0, h1, v0, v1};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task check_dim(input string name, input dim_t exp, input dim_t act);
		check_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("FAIL %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task check_led(input string name, input led_vec_t exp, input led_vec_t act);
		check_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("FAIL %s: expected 0x%02h, actual 0x%02h", name, exp, act);
		end
	endtask

	task check_cfg(input string name, input cfg_word_t exp, input cfg_word_t act);
		check_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("FAIL %s: expected 0x%04h, actual 0x%04h", name, exp, act);
		end
	endtask

	task check_vol(input string name, input vol_att_t exp, input vol_att_t act);
		check_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("FAIL %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task check_sync(input string name, input bit exp, input bit act);
		check_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("FAIL %s: expected %0b, actual %0b", name, exp, act);
		end
	endtask

	task check_window(input string name);
		logic [4*DIM_W-1:0] exp;
		exp = ref_window(m_width, m_height, m_vset, m_hset, m_fs,
			m_arc1x, m_arc1y, m_arc2x, m_arc2y, video_arx, video_ary);
		check_dim($sformatf("%s_hmin", name), exp[4*DIM_W-1 -: DIM_W], hmin);
		check_dim($sformatf("%s_hmax", name), exp[3*DIM_W-1 -: DIM_W], hmax);
		check_dim($sformatf("%s_vmin", name), exp[2*DIM_W-1 -: DIM_W], vmin);
		check_dim($sformatf("%s_vmax", name), exp[DIM_W-1 -: DIM_W], vmax);
	endtask

	task end_test(input string name);
		test_cnt++;
		if (err_cnt == test_err0)
			$display("test %s: pass", name);
		else
			$display("test %s: %0d errors", name, err_cnt - test_err0);
		test_err0 = err_cnt;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// Command word and n words from frame_data before the frame closes
	task send_frame(input cmd_code_t cmd, input int n);
		int i;
		@(negedge clk_sys);
		io_uio    = 1'b1;
		io_strobe = 1'b1;
		io_din    = {8'h00, cmd};
		for (i = 0; i < n; i++) begin
			@(negedge clk_sys);
			io_din = frame_data[i];
		end
		@(negedge clk_sys);
		io_uio    = 1'b0;
		io_strobe = 1'b0;
		io_din    = '0;
	endtask

	task drive_core_leds();
		rng       = xorshift(rng);
		led_user  = rng[0];
		led_power = rng[2:1];
		led_disk  = rng[4:3];
	endtask

	// Raw syncs with active-low pulses
	always @(negedge clk_sys) begin
		if (sync_run) begin
			hs_raw = (h_pos >= HS_LOW);
			vs_raw = (v_pos >= VS_LOW);
			h_pos  = (h_pos == HS_PERIOD - 1) ? 0 : h_pos + 1;
			v_pos  = (v_pos == VS_PERIOD - 1) ? 0 : v_pos + 1;
		end
	end

	// Sync comparator sampled before the DUT registers update
	always @(posedge clk_sys) begin
		if (sync_check) begin
			check_sync("t5_hs_active_high", ~hs_raw, hs);
			check_sync("t5_vs_active_high", ~vs_raw, vs);
			if (!prev_vs)
				check_sync("t5_csync_follows_hs", prev_hs, csync);
		end
		// Active-high levels expected one cycle back
		prev_hs = ~hs_raw;
		prev_vs = ~vs_raw;
	end

	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int mode, i, j, k;
		resetd     = 1'b1;
		io_uio     = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		video_arx  = '0;
		video_ary  = '0;
		led_user   = 1'b0;
		led_power  = '0;
		led_disk   = '0;
		hs_raw     = 1'b1;
		vs_raw     = 1'b1;
		sync_run   = 1'b0;
		sync_check = 1'b0;
		prev_hs    = 1'b0;
		prev_vs    = 1'b0;
		h_pos      = 0;
		v_pos      = 0;
		rng        = 32'd85;
		check_cnt  = 0;
		err_cnt    = 0;
		test_cnt   = 0;
		test_err0  = 0;
		m_width    = DEFAULT_WIDTH;
		m_height   = DEFAULT_HEIGHT;
		m_vset     = '0;
		m_hset     = '0;
		m_fs       = 1'b0;
		m_arc1x    = '0;
		m_arc1y    = '0;
		m_arc2x    = '0;
		m_arc2y    = '0;
		repeat (LEN_RESET) @(negedge clk_sys);
		resetd = 1'b0;

		// Reset values and full-frame window
		repeat (WIN_SETTLE) @(negedge clk_sys);
		check_cfg("t1_cfg", '0, cfg);
		check_vol("t1_vol", '0, vol_att);
		check_dim("t1_hmin", 12'd0, hmin);
		check_dim("t1_hmax", DEFAULT_WIDTH - 12'd1, hmax);
		check_dim("t1_vmin", 12'd0, vmin);
		check_dim("t1_vmax", DEFAULT_HEIGHT - 12'd1, vmax);
		end_test("t1_reset_defaults");

		rng           = xorshift(rng);
		m_cfg         = rng[15:0];
		frame_data[0] = m_cfg;
		send_frame(CMD_CFG, 1);
		check_cfg("t2_cfg", m_cfg, cfg);
		rng           = xorshift(rng);
		m_vol         = rng[VOL_W-1:0];
		frame_data[0] = rng[15:0];
		send_frame(CMD_VOL, 1);
		check_vol("t2_vol", m_vol, vol_att);
		// Unknown command eats its data
		frame_data[0] = ~m_cfg;
		frame_data[1] = ~m_cfg;
		send_frame(8'h55, 2);
		check_cfg("t2_unknown_cmd", m_cfg, cfg);
		for (k = 0; k < 2; k++) begin
			rng           = xorshift(rng);
			m_ovt         = (k == 0) ? 8'h00 : 8'h13;
			m_st          = rng[7:0];
			frame_data[0] = {m_ovt, m_st};
			send_frame(CMD_LED, 1);
			check_led("t2_led_frame", ref_led(m_ovt, m_st, led_user, led_power, led_disk),
				led);
			for (i = 0; i < ITERS; i++) begin
				drive_core_leds();
				@(negedge clk_sys);
				check_led("t2_led_core", ref_led(m_ovt, m_st, led_user, led_power, led_disk),
					led);
			end
		end
		end_test("t2_cfg_vol_led");

		// Mode 1 adds freescale and a horizontal override
		for (mode = 0; mode < 2; mode++) begin
			for (i = 0; i < ITERS; i++) begin
				rng      = xorshift(rng);
				m_width  = dim_t'(640 + rng % 1400);
				rng      = xorshift(rng);
				m_height = dim_t'(360 + rng % 800);
				for (j = 0; j < TIMING_WORDS; j++) begin
					rng           = xorshift(rng);
					frame_data[j] = rng[15:0];
				end
				frame_data[TIMING_WIDTH_IDX]  = {4'h0, m_width};
				frame_data[TIMING_HEIGHT_IDX] = {4'h0, m_height};
				send_frame(CMD_TIMING, TIMING_WORDS);
				if (mode == 1) begin
					rng           = xorshift(rng);
					m_fs          = 1'b1;
					m_hset        = dim_t'(rng % m_width);
					frame_data[0] = {4'h8, m_hset};
					send_frame(CMD_HSET, 1);
				end
				rng       = xorshift(rng);
				video_arx = dim_t'(1 + rng % 64);
				rng       = xorshift(rng);
				video_ary = dim_t'(1 + rng % 64);
				repeat (WIN_SETTLE) @(negedge clk_sys);
				check_window((mode == 0) ? "t3_ratio" : "t3_freescale");
			end
		end
		end_test("t3_timing_window");

		m_fs          = 1'b0;
		m_hset        = '0;
		frame_data[0] = '0;
		send_frame(CMD_HSET, 1);
		m_arc1x       = 12'd4;
		m_arc1y       = 12'd3;
		m_arc2x       = 12'd16;
		m_arc2y       = 12'd9;
		frame_data[0] = {4'h0, m_arc1x};
		frame_data[1] = {4'h0, m_arc1y};
		frame_data[2] = {4'h0, m_arc2x};
		frame_data[3] = {4'h0, m_arc2y};
		send_frame(CMD_ARC, 4);
		m_vset        = m_height - 12'd100;
		frame_data[0] = {4'h0, m_vset};
		send_frame(CMD_VSET, 1);
		video_ary = '0;
		for (k = 1; k <= 2; k++) begin
			video_arx = dim_t'(k);
			repeat (WIN_SETTLE) @(negedge clk_sys);
			check_window((k == 1) ? "t4_arc1" : "t4_arc2");
		end
		end_test("t4_custom_aspect");

		// Polarity settles within two vsync periods
		sync_run = 1'b1;
		repeat (3 * VS_PERIOD) @(negedge clk_sys);
		sync_check = 1'b1;
		repeat (VS_PERIOD) @(negedge clk_sys);
		sync_check = 1'b0;
		end_test("t5_sync_conditioning");

		$display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
